/* rtl/race_pkg.sv */
`default_nettype none

package race_pkg;

    typedef logic [9:0]         pixel_coord_t;   // screen counter or world coordinate
    typedef logic signed [12:0] screen_coord_t;  // signed box arithmetic
    typedef logic [18:0]        map_addr_t;
    typedef logic [1:0]         map_index_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb12_t;

    typedef struct packed {
        pixel_coord_t x;
        pixel_coord_t y;
    } player_pos_t;

    typedef struct packed {
        pixel_coord_t h_cnt;
        pixel_coord_t v_cnt;
        logic         valid;
        logic         hsync;  // active low
        logic         vsync;  // active low
    } scan_t;

    // one pixel's decisions, carried from address generation to the mixer
    typedef struct packed {
        logic valid;
        logic hsync;
        logic vsync;
        logic is_left;
        logic hud_separator;
        logic hud_area;
        logic minimap_area;
        logic separator;
        logic self_box;
        logic enemy_box;
        logic out_of_map;
        logic p1_dot;
        logic p2_dot;
        logic own_finish;
    } pixel_tag_t;

    // 640x480 at 60 Hz
    localparam pixel_coord_t H_VISIBLE = 10'd640;
    localparam pixel_coord_t H_FRONT   = 10'd16;
    localparam pixel_coord_t H_SYNC    = 10'd96;
    localparam pixel_coord_t H_BACK    = 10'd48;
    localparam pixel_coord_t H_TOTAL   = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
    localparam pixel_coord_t V_VISIBLE = 10'd480;
    localparam pixel_coord_t V_FRONT   = 10'd10;
    localparam pixel_coord_t V_SYNC    = 10'd2;
    localparam pixel_coord_t V_BACK    = 10'd33;
    localparam pixel_coord_t V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;

    localparam pixel_coord_t HALF_WIDTH    = 10'd320;
    localparam pixel_coord_t HUD_TOP       = 10'd360;
    localparam pixel_coord_t MINIMAP_LEFT  = 10'd240;
    localparam pixel_coord_t MINIMAP_RIGHT = 10'd400;
    localparam pixel_coord_t MAP_WIDTH     = 10'd640;
    localparam pixel_coord_t MAP_HEIGHT    = 10'd480;
    localparam map_addr_t    MAP_CELLS     = map_addr_t'(MAP_WIDTH) * map_addr_t'(MAP_HEIGHT);
    localparam pixel_coord_t VIEW_OFFSET_X = 10'd40;
    localparam pixel_coord_t VIEW_OFFSET_Y = 10'd45;
    localparam int           ZOOM_SHIFT    = 2;  // 4x zoom

    // own car sits fixed in the middle of its half
    localparam pixel_coord_t  SELF_BOX_LEFT   = 10'd123;
    localparam pixel_coord_t  SELF_BOX_RIGHT  = 10'd197;
    localparam pixel_coord_t  SELF_BOX_TOP    = 10'd143;
    localparam pixel_coord_t  SELF_BOX_BOTTOM = 10'd217;
    localparam screen_coord_t CAR_CENTER_X    = 13'sd160;
    localparam screen_coord_t CAR_CENTER_Y    = 13'sd180;
    localparam screen_coord_t CAR_HALF        = 13'sd37;
    localparam screen_coord_t DOT_RADIUS      = 13'sd6;

    localparam rgb12_t COLOR_BLANK     = 12'h000;
    localparam rgb12_t COLOR_SEPARATOR = 12'hFFF;
    localparam rgb12_t COLOR_HUD       = 12'h444;
    localparam rgb12_t COLOR_OUT_BOUND = 12'h6B4;
    localparam rgb12_t COLOR_P1        = 12'hF00;
    localparam rgb12_t COLOR_P2        = 12'h00F;
    localparam rgb12_t COLOR_P1_WIN    = 12'hFAA;
    localparam rgb12_t COLOR_P2_WIN    = 12'hAAF;

    localparam rgb12_t COLOR_GRASS = 12'h4A2;
    localparam rgb12_t COLOR_ROAD  = 12'h777;
    localparam rgb12_t COLOR_CURB  = 12'hF44;
    localparam rgb12_t COLOR_LINE  = 12'hFFF;

    function automatic rgb12_t palette_color(input map_index_t idx);
        case (idx)
            2'd0:    return COLOR_GRASS;
            2'd1:    return COLOR_ROAD;
            2'd2:    return COLOR_CURB;
            default: return COLOR_LINE;
        endcase
    endfunction

endpackage

`default_nettype wire

/* rtl/vga_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_timing (
    input  wire              clk_25MHz,
    input  wire              rst,
    output race_pkg::scan_t  scan
);
    import race_pkg::*;

    pixel_coord_t h_next;
    pixel_coord_t v_next;
    logic         hsync_next;
    logic         vsync_next;

    // next counter position, so the sync levels line up with the counters
    always_comb begin
        h_next = scan.h_cnt + 10'd1;
        v_next = scan.v_cnt;
        if (scan.h_cnt == H_TOTAL - 10'd1) begin
            h_next = '0;
            if (scan.v_cnt == V_TOTAL - 10'd1) begin
                v_next = '0;
            end else begin
                v_next = scan.v_cnt + 10'd1;
            end
        end
    end

    assign hsync_next = !((h_next >= H_VISIBLE + H_FRONT) &&
                          (h_next <  H_VISIBLE + H_FRONT + H_SYNC));
    assign vsync_next = !((v_next >= V_VISIBLE + V_FRONT) &&
                          (v_next <  V_VISIBLE + V_FRONT + V_SYNC));

    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            scan.h_cnt <= '0;
            scan.v_cnt <= '0;
            scan.valid <= 1'b1;  // pixel (0,0) is visible
            scan.hsync <= 1'b1;
            scan.vsync <= 1'b1;
        end else begin
            scan.h_cnt <= h_next;
            scan.v_cnt <= v_next;
            scan.valid <= (h_next < H_VISIBLE) && (v_next < V_VISIBLE);
            scan.hsync <= hsync_next;
            scan.vsync <= vsync_next;
        end
    end

    // counters never leave the frame
    a_cnt_range: assert property (@(posedge clk_25MHz) disable iff (rst)
        (scan.h_cnt < H_TOTAL) && (scan.v_cnt < V_TOTAL));

endmodule

`default_nettype wire

/* rtl/view_addr_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module view_addr_gen (
    input  wire                   clk_25MHz,
    input  wire                   rst,
    input  race_pkg::scan_t       scan,
    input  race_pkg::player_pos_t p1_pos,
    input  race_pkg::player_pos_t p2_pos,
    input  wire                   p1_finish,
    input  wire                   p2_finish,
    output race_pkg::map_addr_t   map_addr_view,
    output race_pkg::map_addr_t   map_addr_mini,
    output race_pkg::pixel_tag_t  tag
);
    import race_pkg::*;

    function automatic logic dot_hit(input pixel_coord_t mx, input pixel_coord_t my,
                                     input player_pos_t pos);
        screen_coord_t dx;
        screen_coord_t dy;
        dx = $signed({3'b000, mx}) - $signed({3'b000, pos.x});
        dy = $signed({3'b000, my}) - $signed({3'b000, pos.y});
        return (dx >= -DOT_RADIUS) && (dx <= DOT_RADIUS) &&
               (dy >= -DOT_RADIUS) && (dy <= DOT_RADIUS);
    endfunction

    logic          is_left;
    pixel_coord_t  rel_x;
    player_pos_t   own_pos;
    player_pos_t   enemy_pos;
    pixel_coord_t  world_x;
    pixel_coord_t  world_y;
    logic          out_of_map;
    logic          minimap_area;
    pixel_coord_t  mini_x;
    pixel_coord_t  mini_y;
    screen_coord_t diff_x;
    screen_coord_t diff_y;
    screen_coord_t enemy_cx;
    screen_coord_t enemy_cy;
    screen_coord_t scr_x;
    screen_coord_t scr_y;
    logic          self_box;
    logic          enemy_box;
    map_addr_t     view_addr;
    map_addr_t     mini_addr;

    // left half follows player 1, right half player 2
    assign is_left   = scan.h_cnt < HALF_WIDTH;
    assign rel_x     = is_left ? scan.h_cnt : scan.h_cnt - HALF_WIDTH;
    assign own_pos   = is_left ? p1_pos : p2_pos;
    assign enemy_pos = is_left ? p2_pos : p1_pos;

    // window centred on own car, wraps at 10 bits
    assign world_x    = (rel_x >> ZOOM_SHIFT) + own_pos.x - VIEW_OFFSET_X;
    assign world_y    = (scan.v_cnt >> ZOOM_SHIFT) + own_pos.y - VIEW_OFFSET_Y;
    assign out_of_map = (world_x >= MAP_WIDTH) || (world_y >= MAP_HEIGHT);
    assign view_addr  = out_of_map ? '0 :
                        map_addr_t'(world_y) * map_addr_t'(MAP_WIDTH) + map_addr_t'(world_x);

    assign minimap_area = (scan.h_cnt >= MINIMAP_LEFT) && (scan.h_cnt < MINIMAP_RIGHT) &&
                          (scan.v_cnt >= HUD_TOP);
    assign mini_x    = (scan.h_cnt - MINIMAP_LEFT) << ZOOM_SHIFT;  // minimap shrinks 4x
    assign mini_y    = (scan.v_cnt - HUD_TOP) << ZOOM_SHIFT;
    assign mini_addr = minimap_area ?
                       map_addr_t'(mini_y) * map_addr_t'(MAP_WIDTH) + map_addr_t'(mini_x) : '0;

    assign self_box = (rel_x >= SELF_BOX_LEFT) && (rel_x <= SELF_BOX_RIGHT) &&
                      (scan.v_cnt >= SELF_BOX_TOP) && (scan.v_cnt <= SELF_BOX_BOTTOM);

    // enemy offset scaled by the zoom, may fall far off screen
    assign diff_x   = $signed({3'b000, enemy_pos.x}) - $signed({3'b000, own_pos.x});
    assign diff_y   = $signed({3'b000, enemy_pos.y}) - $signed({3'b000, own_pos.y});
    assign enemy_cx = CAR_CENTER_X + (diff_x <<< ZOOM_SHIFT);
    assign enemy_cy = CAR_CENTER_Y + (diff_y <<< ZOOM_SHIFT);
    assign scr_x    = $signed({3'b000, rel_x});
    assign scr_y    = $signed({3'b000, scan.v_cnt});

    assign enemy_box = (scr_x >= enemy_cx - CAR_HALF) && (scr_x <= enemy_cx + CAR_HALF) &&
                       (scr_y >= enemy_cy - CAR_HALF) && (scr_y <= enemy_cy + CAR_HALF);

    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            map_addr_view <= '0;
            map_addr_mini <= '0;
            tag           <= '0;
            tag.hsync     <= 1'b1;
            tag.vsync     <= 1'b1;
        end else begin
            map_addr_view     <= view_addr;
            map_addr_mini     <= mini_addr;
            tag.valid         <= scan.valid;
            tag.hsync         <= scan.hsync;
            tag.vsync         <= scan.vsync;
            tag.is_left       <= is_left;
            tag.hud_separator <= (scan.v_cnt == HUD_TOP - 10'd1) || (scan.v_cnt == HUD_TOP);
            tag.hud_area      <= scan.v_cnt >= HUD_TOP;
            tag.minimap_area  <= minimap_area;
            tag.separator     <= (scan.h_cnt == HALF_WIDTH - 10'd1) ||
                                 (scan.h_cnt == HALF_WIDTH);
            tag.self_box      <= self_box;
            tag.enemy_box     <= enemy_box;
            tag.out_of_map    <= out_of_map;
            tag.p1_dot        <= minimap_area && dot_hit(mini_x, mini_y, p1_pos);
            tag.p2_dot        <= minimap_area && dot_hit(mini_x, mini_y, p2_pos);
            tag.own_finish    <= is_left ? p1_finish : p2_finish;
        end
    end

    a_view_addr_in_map: assert property (@(posedge clk_25MHz) disable iff (rst)
        map_addr_view < MAP_CELLS);

endmodule

`default_nettype wire

/* rtl/pixel_mixer.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_mixer (
    input  wire                  clk_25MHz,
    input  wire                  rst,
    input  race_pkg::pixel_tag_t tag,
    input  race_pkg::map_index_t map_data_view,
    input  race_pkg::map_index_t map_data_mini,
    output race_pkg::rgb12_t     color,
    output logic                 hsync,
    output logic                 vsync
);
    import race_pkg::*;

    pixel_tag_t tag_d;  // lines up with the memory data
    rgb12_t     own_color;
    rgb12_t     enemy_color;
    rgb12_t     win_color;
    rgb12_t     pick;

    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            tag_d       <= '0;
            tag_d.hsync <= 1'b1;
            tag_d.vsync <= 1'b1;
        end else begin
            tag_d <= tag;
        end
    end

    assign own_color   = tag_d.is_left ? COLOR_P1 : COLOR_P2;
    assign enemy_color = tag_d.is_left ? COLOR_P2 : COLOR_P1;
    assign win_color   = tag_d.is_left ? COLOR_P1_WIN : COLOR_P2_WIN;

    // first match wins
    always_comb begin
        if (!tag_d.valid) begin
            pick = COLOR_BLANK;
        end else if (tag_d.hud_separator) begin
            pick = COLOR_SEPARATOR;
        end else if (tag_d.hud_area) begin
            if (tag_d.p1_dot) begin
                pick = COLOR_P1;  // red on top where dots overlap
            end else if (tag_d.p2_dot) begin
                pick = COLOR_P2;
            end else if (tag_d.minimap_area) begin
                pick = palette_color(map_data_mini);
            end else begin
                pick = COLOR_HUD;
            end
        end else if (tag_d.separator) begin
            pick = COLOR_SEPARATOR;
        end else if (tag_d.own_finish) begin
            pick = win_color;  // whole half tinted
        end else if (tag_d.self_box) begin
            pick = own_color;
        end else if (tag_d.enemy_box) begin
            pick = enemy_color;
        end else if (tag_d.out_of_map) begin
            pick = COLOR_OUT_BOUND;
        end else begin
            pick = palette_color(map_data_view);
        end
    end

    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            color <= COLOR_BLANK;
            hsync <= 1'b1;
            vsync <= 1'b1;
        end else begin
            color <= pick;
            hsync <= tag_d.hsync;  // syncs ride with the colour
            vsync <= tag_d.vsync;
        end
    end

    // blanking reaches the pins as black one cycle later
    a_blank_black: assert property (@(posedge clk_25MHz) disable iff (rst)
        !tag_d.valid |=> (color == COLOR_BLANK));

endmodule

`default_nettype wire

/* rtl/race_view_top.sv */
`timescale 1ns/1ps
`default_nettype none

module race_view_top (
    input  wire                   clk_25MHz,
    input  wire                   rst,
    input  race_pkg::player_pos_t p1_pos,
    input  race_pkg::player_pos_t p2_pos,
    input  wire                   p1_finish,
    input  wire                   p2_finish,
    input  race_pkg::map_index_t  map_data_view,
    input  race_pkg::map_index_t  map_data_mini,
    output race_pkg::map_addr_t   map_addr_view,
    output race_pkg::map_addr_t   map_addr_mini,
    output wire [3:0]             vga_red,
    output wire [3:0]             vga_green,
    output wire [3:0]             vga_blue,
    output wire                   hsync,
    output wire                   vsync
);
    import race_pkg::*;

    scan_t      scan;
    pixel_tag_t tag;
    rgb12_t     color;

    vga_timing u_timing (
        .clk_25MHz (clk_25MHz),
        .rst       (rst),
        .scan      (scan)
    );

    // addresses leave for the external map memory here
    view_addr_gen u_addr (
        .clk_25MHz     (clk_25MHz),
        .rst           (rst),
        .scan          (scan),
        .p1_pos        (p1_pos),
        .p2_pos        (p2_pos),
        .p1_finish     (p1_finish),
        .p2_finish     (p2_finish),
        .map_addr_view (map_addr_view),
        .map_addr_mini (map_addr_mini),
        .tag           (tag)
    );

    pixel_mixer u_mixer (
        .clk_25MHz     (clk_25MHz),
        .rst           (rst),
        .tag           (tag),
        .map_data_view (map_data_view),
        .map_data_mini (map_data_mini),
        .color         (color),
        .hsync         (hsync),
        .vsync         (vsync)
    );

    assign vga_red   = color.r;
    assign vga_green = color.g;
    assign vga_blue  = color.b;

endmodule

`default_nettype wire

/* tests/race_view_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module race_view_checker (
    input  wire                   clk_25MHz,
    input  wire                   rst,
    input  wire [127:0]           test_name,
    input  race_pkg::player_pos_t p1_pos,
    input  race_pkg::player_pos_t p2_pos,
    input  wire                   p1_finish,
    input  wire                   p2_finish,
    input  race_pkg::map_addr_t   map_addr_view,
    input  race_pkg::map_addr_t   map_addr_mini,
    input  wire [3:0]             vga_red,
    input  wire [3:0]             vga_green,
    input  wire [3:0]             vga_blue,
    input  wire                   hsync,
    input  wire                   vsync,
    output int                    sync_errors,
    output int                    addr_errors,
    output int                    color_errors,
    output int                    pixels_checked
);
    import race_pkg::*;

    int        h;  // screen position of the pixel now at the pins
    int        v;
    logic      locked;
    logic      vsync_prev;
    map_addr_t view_d1, view_d2;
    map_addr_t mini_d1, mini_d2;

    function automatic int palette(input int idx);
        case (idx)
            0:       return 32'h4A2;
            1:       return 32'h777;
            2:       return 32'hF44;
            default: return 32'hFFF;
        endcase
    endfunction

    // -1 when the view pixel falls outside the map
    function automatic int world_addr(input int hh, input int vv);
        int rel, ox, oy, wx, wy;
        rel = (hh < 320) ? hh : hh - 320;
        ox  = (hh < 320) ? int'(p1_pos.x) : int'(p2_pos.x);
        oy  = (hh < 320) ? int'(p1_pos.y) : int'(p2_pos.y);
        wx  = (rel / 4 + ox - 40) & 1023;  // 10-bit wrap
        wy  = (vv / 4 + oy - 45) & 1023;
        if (wx >= 640 || wy >= 480) return -1;
        return wy * 640 + wx;
    endfunction

    function automatic logic in_minimap(input int hh, input int vv);
        return hh >= 240 && hh < 400 && vv >= 360;
    endfunction

    function automatic int mini_addr(input int hh, input int vv);
        if (!in_minimap(hh, vv)) return 0;
        return (vv - 360) * 4 * 640 + (hh - 240) * 4;
    endfunction

    function automatic logic near_dot(input int hh, input int vv, input player_pos_t pos);
        int dx, dy;
        dx = (hh - 240) * 4 - int'(pos.x);
        dy = (vv - 360) * 4 - int'(pos.y);
        return in_minimap(hh, vv) && dx >= -6 && dx <= 6 && dy >= -6 && dy <= 6;
    endfunction

    function automatic int expect_color(input int hh, input int vv);
        int          rel, ecx, ecy, waddr;
        logic        left;
        player_pos_t own;
        player_pos_t other;
        left  = hh < 320;
        rel   = left ? hh : hh - 320;
        own   = left ? p1_pos : p2_pos;
        other = left ? p2_pos : p1_pos;
        ecx   = 160 + 4 * (int'(other.x) - int'(own.x));
        ecy   = 180 + 4 * (int'(other.y) - int'(own.y));
        waddr = world_addr(hh, vv);
        if (hh >= 640 || vv >= 480) return 32'h000;
        if (vv == 359 || vv == 360) return 32'hFFF;
        if (vv > 360) begin
            if (near_dot(hh, vv, p1_pos)) return 32'hF00;  // red on top
            if (near_dot(hh, vv, p2_pos)) return 32'h00F;
            if (in_minimap(hh, vv)) return palette(mini_addr(hh, vv) / 8 % 4);
            return 32'h444;
        end
        if (hh == 319 || hh == 320) return 32'hFFF;
        if (left ? p1_finish : p2_finish) return left ? 32'hFAA : 32'hAAF;
        if (rel >= 123 && rel <= 197 && vv >= 143 && vv <= 217) begin
            return left ? 32'hF00 : 32'h00F;
        end
        if (rel >= ecx - 37 && rel <= ecx + 37 && vv >= ecy - 37 && vv <= ecy + 37) begin
            return left ? 32'h00F : 32'hF00;
        end
        if (waddr < 0) return 32'h6B4;
        return palette(waddr / 8 % 4);
    endfunction

    task automatic report_mismatch(input string what, input int expected, input int actual);
        $display("CHECK FAILED %0s %0s at (%0d,%0d) expected %0h actual %0h",
                 test_name, what, h, v, expected, actual);
    endtask

    task automatic check_pixel();
        logic exp_hs;
        logic exp_vs;
        int   exp_view;
        int   exp_color;
        int   got_color;
        exp_hs    = !(h >= 656 && h < 752);
        exp_vs    = !(v >= 490 && v < 492);
        exp_color = expect_color(h, v);
        got_color = int'({vga_red, vga_green, vga_blue});
        pixels_checked++;
        if (hsync !== exp_hs) begin
            sync_errors++;
            report_mismatch("hsync", int'(exp_hs), int'(hsync));
        end
        if (vsync !== exp_vs) begin
            sync_errors++;
            report_mismatch("vsync", int'(exp_vs), int'(vsync));
        end
        if (got_color != exp_color) begin
            color_errors++;
            report_mismatch("colour", exp_color, got_color);
        end
        // addresses left the DUT two cycles before this colour
        if (h < 640 && v < 480) begin
            exp_view = world_addr(h, v);
            if (exp_view < 0) exp_view = 0;
            if (int'(view_d2) != exp_view) begin
                addr_errors++;
                report_mismatch("map_addr_view", exp_view, int'(view_d2));
            end
            if (int'(mini_d2) != mini_addr(h, v)) begin
                addr_errors++;
                report_mismatch("map_addr_mini", mini_addr(h, v), int'(mini_d2));
            end
        end
    endtask

    always @(negedge clk_25MHz) begin
        if (rst) begin
            locked         = 1'b0;
            vsync_prev     = 1'b1;
            sync_errors    = 0;
            addr_errors    = 0;
            color_errors   = 0;
            pixels_checked = 0;
        end else begin
            if (locked) begin
                h = h + 1;
                if (h == 800) begin
                    h = 0;
                    v = (v == 524) ? 0 : v + 1;
                end
            end else if (vsync_prev && !vsync) begin
                locked = 1'b1;  // first low vsync pixel is (0,490)
                h      = 0;
                v      = 490;
            end
            if (locked) check_pixel();
            vsync_prev = vsync;
            view_d2    = view_d1;
            view_d1    = map_addr_view;
            mini_d2    = mini_d1;
            mini_d1    = map_addr_mini;
        end
    end

endmodule

`default_nettype wire

/* tests/tb_race_view.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_race_view;
    import race_pkg::*;

    localparam int    CLK_HALF     = 20;  // 25 MHz
    localparam int    DRIVE_DELAY  = 2;
    localparam int    FRAME_CYCLES = 800 * 525;
    localparam string TEST_FILE    = "tests/race_view_tests.txt";

    typedef struct packed {
        logic [127:0] name;
        player_pos_t  p1;
        player_pos_t  p2;
        logic         p1_fin;
        logic         p2_fin;
        logic [15:0]  frames;
    } test_t;

    logic         clk_25MHz;
    logic         rst;
    player_pos_t  p1_pos;
    player_pos_t  p2_pos;
    logic         p1_finish;
    logic         p2_finish;
    map_index_t   map_data_view = '0;
    map_index_t   map_data_mini = '0;
    map_addr_t    map_addr_view;
    map_addr_t    map_addr_mini;
    logic [3:0]   vga_red, vga_green, vga_blue;
    logic         hsync;
    logic         vsync;
    logic [127:0] test_name;
    int           sync_errors, addr_errors, color_errors, pixels_checked;
    test_t        tests[$];
    int           cycles = 0;
    int           cycle_limit = 0;

    initial begin
        clk_25MHz = 1'b0;
        forever #CLK_HALF clk_25MHz = ~clk_25MHz;
    end

    race_view_top DUT (
        .clk_25MHz     (clk_25MHz),
        .rst           (rst),
        .p1_pos        (p1_pos),
        .p2_pos        (p2_pos),
        .p1_finish     (p1_finish),
        .p2_finish     (p2_finish),
        .map_data_view (map_data_view),
        .map_data_mini (map_data_mini),
        .map_addr_view (map_addr_view),
        .map_addr_mini (map_addr_mini),
        .vga_red       (vga_red),
        .vga_green     (vga_green),
        .vga_blue      (vga_blue),
        .hsync         (hsync),
        .vsync         (vsync)
    );

    // map memory, one registered read per port
    always @(posedge clk_25MHz) begin
        map_data_view <= map_index_t'(map_addr_view >> 3);  // addr / 8 mod 4
        map_data_mini <= map_index_t'(map_addr_mini >> 3);
    end

    race_view_checker u_checker (
        .clk_25MHz      (clk_25MHz),
        .rst            (rst),
        .test_name      (test_name),
        .p1_pos         (p1_pos),
        .p2_pos         (p2_pos),
        .p1_finish      (p1_finish),
        .p2_finish      (p2_finish),
        .map_addr_view  (map_addr_view),
        .map_addr_mini  (map_addr_mini),
        .vga_red        (vga_red),
        .vga_green      (vga_green),
        .vga_blue       (vga_blue),
        .hsync          (hsync),
        .vsync          (vsync),
        .sync_errors    (sync_errors),
        .addr_errors    (addr_errors),
        .color_errors   (color_errors),
        .pixels_checked (pixels_checked)
    );

    task automatic load_tests(output int total_frames);
        int           fd;
        int           n;
        int           p1x, p1y, p2x, p2y, f1, f2, frames;
        logic [127:0] name;
        string        line;
        test_t        t;
        total_frames = 0;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) return;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // comment lines stop after the first field
            if (n > 0 && $sscanf(line, "%s %d %d %d %d %d %d %d", name,
                                 p1x, p1y, p2x, p2y, f1, f2, frames) == 8) begin
                t.name   = name;
                t.p1.x   = pixel_coord_t'(p1x);
                t.p1.y   = pixel_coord_t'(p1y);
                t.p2.x   = pixel_coord_t'(p2x);
                t.p2.y   = pixel_coord_t'(p2y);
                t.p1_fin = f1 != 0;
                t.p2_fin = f2 != 0;
                t.frames = 16'(frames);
                tests.push_back(t);
                total_frames += frames;
            end
        end
        $fclose(fd);
    endtask

    task automatic apply_test(input test_t t);
        test_name = t.name;
        p1_pos    = t.p1;
        p2_pos    = t.p2;
        p1_finish = t.p1_fin;
        p2_finish = t.p2_fin;
        $display("running %0s for %0d frame(s)", t.name, t.frames);
    endtask

    initial begin
        int total_frames;
        rst       = 1'b1;
        p1_pos    = '0;
        p2_pos    = '0;
        p1_finish = 1'b0;
        p2_finish = 1'b0;
        test_name = "reset";
        load_tests(total_frames);
        if (tests.size() == 0) begin
            $display("no tests could be read from %0s", TEST_FILE);
            $display("Test FAILED");
            $finish;
        end else begin
            cycle_limit = (total_frames + 2) * FRAME_CYCLES;  // two frames of margin
            repeat (8) @(posedge clk_25MHz);
            #DRIVE_DELAY;
            rst = 1'b0;
            @(negedge vsync);
            foreach (tests[i]) begin
                #DRIVE_DELAY;  // inputs move only inside vsync
                apply_test(tests[i]);
                repeat (tests[i].frames) @(negedge vsync);
            end
            $display("errors: sync %0d, address %0d, colour %0d, pixels checked %0d",
                     sync_errors, addr_errors, color_errors, pixels_checked);
            if (sync_errors + addr_errors + color_errors == 0 && pixels_checked > 0) begin
                $display("Test OK");
            end else begin
                $display("Test FAILED");
            end
            $finish;
        end
    end

    always @(posedge clk_25MHz) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Test FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* list.f */
rtl/race_pkg.sv
rtl/vga_timing.sv
rtl/view_addr_gen.sv
rtl/pixel_mixer.sv
rtl/race_view_top.sv
tests/race_view_checker.sv
tests/tb_race_view.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_race_view
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
FILELIST  ?= list.f
DATA      ?= tests/race_view_tests.txt

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN) $(DATA)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/race_view_tests.txt */
# name p1_x p1_y p2_x p2_y p1_finish p2_finish frames
# positions in map pixels, finish flags 0 or 1
start_grid 100 100 110 105 0 0 1
far_apart 100 100 500 400 0 0 1
edge_view 620 20 300 240 0 0 1
dots_overlap 200 150 202 151 0 0 1
p1_wins 320 240 100 400 1 0 1
p2_wins 400 300 150 200 0 1 1
both_win 50 60 600 450 1 1 1
